/* src/memUnitPkg.sv */
`default_nettype none

package memUnitPkg;

    // Data and address widths of the memory unit.
    typedef logic [31:0] memWord_t;
    typedef logic [31:0] memAddr_t;

    // One bit wider than the reorder-buffer index.
    localparam int ROB_TAG_BITS = 5;
    typedef logic [ROB_TAG_BITS-1:0] robTag_t;

    // Bits [1:0] give the width, bit 2 marks an unsigned load.
    typedef logic [2:0] accessSize_t;

    localparam accessSize_t SIZE_BYTE   = 3'b000;
    localparam accessSize_t SIZE_HALF   = 3'b001;
    localparam accessSize_t SIZE_WORD   = 3'b010;
    localparam accessSize_t SIZE_BYTE_U = 3'b100;
    localparam accessSize_t SIZE_HALF_U = 3'b101;

    localparam int WORD_BYTES = 4;

endpackage

`default_nettype wire

/* src/memReqIf.sv */
`default_nettype none

interface memReqIf #(
    parameter int memWords = 1024
);

    localparam int indexBits = $clog2(memWords);

    logic                     valid;      // One-cycle pulse per request.
    logic                     isStore;
    memUnitPkg::accessSize_t  size;
    logic [indexBits-1:0]     wordIndex;
    logic [1:0]               byteOffset;
    memUnitPkg::memWord_t     storeData;
    memUnitPkg::robTag_t      tag;
    logic                     invalid;    // Out of range or misaligned.

    modport addrSide (
        output valid, isStore, size, wordIndex, byteOffset, storeData, tag, invalid
    );

    modport memSide (
        input valid, isStore, size, wordIndex, byteOffset, storeData, invalid
    );

    modport resultSide (
        input valid, isStore, size, byteOffset, tag, invalid
    );

endinterface

`default_nettype wire

/* src/memAddrUnit.sv */
`default_nettype none

module memAddrUnit #(
    parameter int memWords = 1024
) (
    input  wire logic                    clk,
    input  wire logic                    rstN,
    input  wire logic                    reqValid,
    input  wire logic                    reqIsStore,
    input  wire memUnitPkg::accessSize_t reqSize,
    input  wire memUnitPkg::robTag_t     reqTag,
    input  wire memUnitPkg::memWord_t    baseValue,
    input  wire memUnitPkg::memWord_t    immediate,
    input  wire memUnitPkg::memWord_t    storeData,
    memReqIf.addrSide                    req
);

    localparam int indexBits = $clog2(memWords);

    memUnitPkg::memAddr_t effAddr;
    logic                 outOfRange;
    logic                 misaligned;

    assign effAddr = baseValue + immediate; // Wraps modulo 2**32.

    // Anything at or above 4*memWords bytes has a nonzero upper part.
    assign outOfRange = |effAddr[31:indexBits+2];

    always_comb begin
        case (reqSize)
            memUnitPkg::SIZE_BYTE,
            memUnitPkg::SIZE_BYTE_U: misaligned = 1'b0;
            memUnitPkg::SIZE_HALF,
            memUnitPkg::SIZE_HALF_U: misaligned = effAddr[0];
            memUnitPkg::SIZE_WORD:   misaligned = |effAddr[1:0];
            default:                 misaligned = 1'b1; // Unknown size is never served.
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= reqValid;
        end
    end

    always_ff @(posedge clk) begin
        req.isStore    <= reqIsStore;
        req.size       <= reqSize;
        req.wordIndex  <= effAddr[indexBits+1:2];
        req.byteOffset <= effAddr[1:0];
        req.storeData  <= storeData;
        req.tag        <= reqTag;
        req.invalid    <= outOfRange | misaligned;
    end

    validKnown: assert property (
        @(posedge clk) disable iff (!rstN)
        !$isunknown(req.valid)
    ) else $error("memAddrUnit: request valid is unknown");

endmodule

`default_nettype wire

/* src/dataMemory.sv */
`default_nettype none

module dataMemory #(
    parameter int memWords = 1024
) (
    input  wire logic                 clk,
    memReqIf.memSide                  req,
    output memUnitPkg::memWord_t      readData
);

    memUnitPkg::memWord_t mem [memWords];

    logic [memUnitPkg::WORD_BYTES-1:0] laneMask;
    logic [memUnitPkg::WORD_BYTES-1:0] writeEnable;
    memUnitPkg::memWord_t              writeData;
    logic                              storeOk;

    // Byte lanes touched by the access.
    always_comb begin
        case (req.size)
            memUnitPkg::SIZE_BYTE,
            memUnitPkg::SIZE_BYTE_U: laneMask = 4'b0001 << req.byteOffset;
            memUnitPkg::SIZE_HALF,
            memUnitPkg::SIZE_HALF_U: laneMask = 4'b0011 << req.byteOffset;
            default:                 laneMask = 4'b1111;
        endcase
    end

    assign storeOk = req.valid & req.isStore & ~req.invalid;
    assign writeEnable = {memUnitPkg::WORD_BYTES{storeOk}} & laneMask;

    // Store data sits in the low bits, move it onto its lanes.
    assign writeData = req.storeData << {req.byteOffset, 3'b000};

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < memUnitPkg::WORD_BYTES; lane++) begin
            if (writeEnable[lane]) begin
                mem[req.wordIndex][lane*8 +: 8] <= writeData[lane*8 +: 8];
            end
        end
    end

    // Read data is registered on every request, loads and stores alike.
    always_ff @(posedge clk) begin
        if (req.valid) begin
            readData <= mem[req.wordIndex];
        end
    end

    // An invalid store leaves the addressed word as it was.
    noInvalidWrite: assert property (
        @(posedge clk)
        (req.valid && req.isStore && req.invalid)
            |=> (mem[$past(req.wordIndex)] === $past(mem[req.wordIndex]))
    ) else $error("dataMemory: invalid store changed the memory");

endmodule

`default_nettype wire

/* src/memResultBus.sv */
`default_nettype none

module memResultBus (
    input  wire logic                  clk,
    input  wire logic                  rstN,
    memReqIf.resultSide                req,
    input  wire memUnitPkg::memWord_t  readData,
    output logic                       cdbValid,
    output memUnitPkg::robTag_t        cdbTag,
    output memUnitPkg::memWord_t       cdbValue,
    output logic                       cdbInvalidAddress
);

    // Status of the request whose word is now in readData.
    logic                    validQ;
    memUnitPkg::robTag_t     tagQ;
    memUnitPkg::accessSize_t sizeQ;
    logic [1:0]              offsetQ;
    logic                    isStoreQ;
    logic                    invalidQ;

    memUnitPkg::memWord_t    shifted;
    memUnitPkg::memWord_t    loadValue;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        tagQ     <= req.tag;
        sizeQ    <= req.size;
        offsetQ  <= req.byteOffset;
        isStoreQ <= req.isStore;
        invalidQ <= req.invalid;
    end

    assign shifted = readData >> {offsetQ, 3'b000};

    always_comb begin
        case (sizeQ)
            memUnitPkg::SIZE_BYTE:   loadValue = {{24{shifted[7]}}, shifted[7:0]};
            memUnitPkg::SIZE_BYTE_U: loadValue = {24'h0, shifted[7:0]};
            memUnitPkg::SIZE_HALF:   loadValue = {{16{shifted[15]}}, shifted[15:0]};
            memUnitPkg::SIZE_HALF_U: loadValue = {16'h0, shifted[15:0]};
            default:                 loadValue = readData;
        endcase
    end

    assign cdbValid          = validQ;
    assign cdbTag            = tagQ;
    assign cdbValue          = (isStoreQ || invalidQ) ? '0 : loadValue; // Stores report zero.
    assign cdbInvalidAddress = validQ & invalidQ;

    // An invalid request on the interface comes out flagged, with value zero.
    invalidIsZero: assert property (
        @(posedge clk) disable iff (!rstN)
        (req.valid && req.invalid) |=> (cdbInvalidAddress && cdbValue == '0)
    ) else $error("memResultBus: invalid access not reported with zero value");

endmodule

`default_nettype wire

/* src/memUnitTop.sv */
`default_nettype none

module memUnitTop #(
    parameter int memWords = 1024
) (
    input  wire logic                    clk,
    input  wire logic                    rstN,
    input  wire logic                    reqValid,
    input  wire logic                    reqIsStore,
    input  wire memUnitPkg::accessSize_t reqSize,
    input  wire memUnitPkg::robTag_t     reqTag,
    input  wire memUnitPkg::memWord_t    baseValue,
    input  wire memUnitPkg::memWord_t    immediate,
    input  wire memUnitPkg::memWord_t    storeData,
    output memUnitPkg::memWord_t         cdbValue,
    output memUnitPkg::robTag_t          cdbTag,
    output logic                         cdbValid,
    output logic                         cdbInvalidAddress
);

    memReqIf #(.memWords(memWords)) req ();

    memUnitPkg::memWord_t readData;

    memAddrUnit #(
        .memWords (memWords)
    ) addrUnit (
        .clk        (clk),
        .rstN       (rstN),
        .reqValid   (reqValid),
        .reqIsStore (reqIsStore),
        .reqSize    (reqSize),
        .reqTag     (reqTag),
        .baseValue  (baseValue),
        .immediate  (immediate),
        .storeData  (storeData),
        .req        (req.addrSide)
    );

    // Memory read and status registers run side by side.
    dataMemory #(
        .memWords (memWords)
    ) memory (
        .clk      (clk),
        .req      (req.memSide),
        .readData (readData)
    );

    memResultBus resultBus (
        .clk               (clk),
        .rstN              (rstN),
        .req               (req.resultSide),
        .readData          (readData),
        .cdbValid          (cdbValid),
        .cdbTag            (cdbTag),
        .cdbValue          (cdbValue),
        .cdbInvalidAddress (cdbInvalidAddress)
    );

endmodule

`default_nettype wire

/* dv/tbClock.sv */
`default_nettype none

module tbClock #(
    parameter int period      = 4,
    parameter int resetCycles = 10
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rstN <= 1'b0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1; // Released just after the last reset edge.
    end

endmodule

`default_nettype wire

/* dv/memUnitTb.sv */
`default_nettype none

module memUnitTb;

    localparam int resetCycles  = 10;
    localparam int fieldsPerReq = 9; // Columns per line of the stimulus file.
    localparam int maxReqs      = 64;

    typedef struct packed {
        int                   due; // Cycle on which the broadcast is seen.
        memUnitPkg::robTag_t  tag;
        logic                 invalid;
        memUnitPkg::memWord_t value;
    } expectEntry_t;

    logic                    clk;
    logic                    rstN;
    logic                    reqValid;
    logic                    reqIsStore;
    memUnitPkg::accessSize_t reqSize;
    memUnitPkg::robTag_t     reqTag;
    memUnitPkg::memWord_t    baseValue;
    memUnitPkg::memWord_t    immediate;
    memUnitPkg::memWord_t    storeData;
    memUnitPkg::memWord_t    cdbValue;
    memUnitPkg::robTag_t     cdbTag;
    logic                    cdbValid;
    logic                    cdbInvalidAddress;

    logic [31:0]  stim [fieldsPerReq*maxReqs];
    int           numReqs;
    bit           stimLoaded;
    int           cycle;
    logic [31:0]  lfsr = 32'hbc4d8955;
    expectEntry_t expQ[$];

    tbClock #(.period(4), .resetCycles(resetCycles)) clockGen (.clk(clk), .rstN(rstN));

    memUnitTop #(.memWords(1024)) dut (.*);

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit.
    function automatic int drawIdle();
        int idle = 0;
        for (int b = 0; b < 2; b++) begin
            idle = (idle << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
        end
        return idle;
    endfunction

    task automatic checkEqual(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic runRequests();
        int base;
        int idle;
        while (rstN !== 1'b1) begin
            @(posedge clk);
        end
        for (int i = 0; i < numReqs; i++) begin
            base = i * fieldsPerReq;
            @(posedge clk);
            reqValid   <= 1'b1;
            reqIsStore <= stim[base][0];
            reqSize    <= stim[base+1][2:0];
            reqTag     <= stim[base+2][4:0];
            baseValue  <= stim[base+3];
            immediate  <= stim[base+4];
            storeData  <= stim[base+5];
            // Sampled at the next edge, status registered at the one after, seen at the third.
            expQ.push_back(expectEntry_t'{cycle + 3, stim[base+2][4:0],
                                          stim[base+6][0], stim[base+7]});
            idle = stim[base+8][0] ? 0 : drawIdle();
            repeat (idle) begin
                @(posedge clk);
                reqValid <= 1'b0;
            end
        end
        @(posedge clk);
        reqValid <= 1'b0;
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk); // Room for a stray broadcast.
    endtask

    initial begin
        reqValid   <= 1'b0;
        reqIsStore <= 1'b0;
        reqSize    <= memUnitPkg::SIZE_WORD;
        reqTag     <= '0;
        baseValue  <= '0;
        immediate  <= '0;
        storeData  <= '0;
        $readmemh("dv/memUnitStim.txt", stim);
        // The list ends at the first line whose store flag is not 0 or 1.
        while (numReqs < maxReqs && stim[numReqs*fieldsPerReq] inside {32'h0, 32'h1}) begin
            numReqs++;
        end
        stimLoaded = 1'b1;
        if (numReqs == 0) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "The stimulus file holds no requests");
        end else begin
            runRequests();
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

    always @(posedge clk) begin : monitor
        expectEntry_t want;
        if (rstN === 1'b1 && cdbValid === 1'b1) begin
            if (expQ.size() == 0) begin
                $display("TESTBENCH FAILED");
                $fatal(1, "Broadcast with tag 0x%0h came while none was pending", cdbTag);
            end else begin
                want = expQ.pop_front();
                checkEqual("arrivalCycle", cycle, want.due);
                checkEqual("cdbTag", 32'(cdbTag), 32'(want.tag));
                checkEqual("cdbInvalidAddress", 32'(cdbInvalidAddress), 32'(want.invalid));
                checkEqual("cdbValue", cdbValue, want.value);
            end
        end else if (expQ.size() != 0 && cycle > expQ[0].due) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "Broadcast for tag 0x%0h missing, it was due on cycle %0d",
                   expQ[0].tag, expQ[0].due);
        end
    end

    initial begin
        wait (stimLoaded);
        repeat (resetCycles + 8 * numReqs) @(posedge clk);
        $display("TESTBENCH FAILED");
        $fatal(1, "Timeout, the run took more than %0d cycles", resetCycles + 8 * numReqs);
    end

endmodule

`default_nettype wire

/* vlog.f */
src/memUnitPkg.sv
src/memReqIf.sv
src/memAddrUnit.sv
src/dataMemory.sv
src/memResultBus.sv
src/memUnitTop.sv
dv/tbClock.sv
dv/memUnitTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = memUnitTb
FILELIST  = vlog.f
OBJDIR    = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* dv/memUnitStim.txt */
// Columns: store, size, tag, base, immediate, store data, expected invalid,
// expected value, next request follows directly. A store flag of ff ends the list.
1 2 01 00000100 00000000 12345678 0 00000000 1
0 2 02 00000100 00000000 00000000 0 12345678 0
1 2 03 00000200 00000004 8899aabb 0 00000000 0
0 2 04 00000208 fffffffc 00000000 0 8899aabb 0
1 0 05 00000200 00000005 000000f0 0 00000000 0
1 1 06 00000206 00000000 00007e01 0 00000000 1
0 2 07 00000204 00000000 00000000 0 7e01f0bb 1
0 0 08 00000205 00000000 00000000 0 fffffff0 1
0 4 09 00000205 00000000 00000000 0 000000f0 0
0 1 0a 00000204 00000000 00000000 0 fffff0bb 0
0 5 0b 00000204 00000000 00000000 0 0000f0bb 0
0 1 0c 00000206 00000000 00000000 0 00007e01 0
0 0 0d 00000207 00000000 00000000 0 0000007e 0
0 2 0e 00001000 00000000 00000000 1 00000000 0
0 2 0f 00000000 fffffffc 00000000 1 00000000 0
0 1 10 00000101 00000000 00000000 1 00000000 0
1 2 11 00001000 00000100 cafef00d 1 00000000 1 // Would alias word 0x100.
1 2 12 00000100 00000002 deadbeef 1 00000000 1
0 2 13 00000100 00000000 00000000 0 12345678 0
1 1 14 00000205 00000000 0000ffff 1 00000000 1
0 2 15 00000204 00000000 00000000 0 7e01f0bb 0
ff
